// File: sources.f
src/cobs_pkg.sv
src/stream_fifo.sv
src/cobs_segmenter.sv
src/cobs_emitter.sv
src/stream_skid_buffer.sv
src/cobs_encode_top.sv
verif/tb_cobs_encode.sv

// File: Makefile
TOP       ?= tb_cobs_encode
SIM_DIR   ?= sim_build
DATA      ?= verif/cobs_input.txt
LOG       ?= $(SIM_DIR)/sim.log
FILELIST  ?= sources.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(SIM_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(SIM_DIR) -o V$(TOP)

run: $(SIM_DIR)/V$(TOP) $(DATA)
	./$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR)

// File: verif/cobs_input.txt
# frame: hex bytes closed by end, or by err when the last byte carries the error flag
# exp: encoded bytes expected for the frame above; gen N: N random nonzero bytes
frame 11 22 00 33 end
exp 03 11 22 02 33 00 end
frame 00 end
exp 01 01 00 end
frame 00 00 45 end
exp 01 01 02 45 00 end
frame 5a 00 00 end
exp 02 5a 01 01 00 end
frame 01 02 03 00 04 05 00 06 end
exp 04 01 02 03 03 04 05 02 06 00 end
gen 600
gen 254
frame 7e 00 81 err
exp 02 7e 01 02 00 end
frame 33 44 err
exp 02 33 02 00 end
# random input gaps and output back-pressure from here on
stall
frame 11 22 00 33 end
exp 03 11 22 02 33 00 end
frame 00 end
exp 01 01 00 end
frame 00 00 45 end
exp 01 01 02 45 00 end
frame 5a 00 00 end
exp 02 5a 01 01 00 end
frame 01 02 03 00 04 05 00 06 end
exp 04 01 02 03 03 04 05 02 06 00 end
gen 300

// File: verif/tb_cobs_encode.sv
`default_nettype none

module tb_cobs_encode;

    localparam int CLK_PERIOD = 100;
    // cycles watched after the last expected beat for anything extra
    localparam int DRAIN_CYCLES = 64;

    logic clk;
    logic rst;
    cobs_pkg::stream_beat_t in_beat;
    logic in_valid;
    logic in_ready;
    cobs_pkg::stream_beat_t out_beat;
    logic out_valid;
    logic out_ready;

    // input beats as {gaps enabled, beat}
    logic [10:0] in_q[$];
    // expected output beats, and the beat count of each frame
    logic [9:0] exp_q[$];
    int exp_len[$];

    logic [7:0] frame[$];
    logic [7:0] seg[$];
    logic [7:0] ref_q[$];
    logic [7:0] file_exp[$];

    logic [31:0] gen_state;
    logic [31:0] ready_state;
    logic stall_on;
    logic stall_now;
    int ready_draw;
    int errors;
    int frames_ok;
    int frames_bad;
    int out_lasts;
    longint watchdog_time = 0;

    cobs_encode_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic lfsr_bits(inout logic [31:0] s, input int nbits, output int value);
        value = 0;
        repeat (nbits) begin
            s = lfsr_step(s);
            value = {value[30:0], s[0]};
        end
    endtask

    // a segment leaves as its code followed by its bytes
    task automatic close_segment();
        ref_q.push_back(8'(seg.size() + 1));
        foreach (seg[i]) begin
            ref_q.push_back(seg[i]);
        end
        seg.delete();
    endtask

    task automatic encode_reference(input bit err);
        int n;
        bit split;
        ref_q.delete();
        seg.delete();
        split = 1'b0;
        // the errored byte itself is dropped
        n = err ? frame.size() - 1 : frame.size();
        for (int i = 0; i < n; i++) begin
            split = 1'b0;
            if (frame[i] == 8'h00) begin
                close_segment();
            end else begin
                seg.push_back(frame[i]);
                if (seg.size() == cobs_pkg::MAX_CODE - 1) begin
                    close_segment();
                    split = 1'b1;
                end
            end
        end
        // a frame ending on a full block gets no empty final segment
        if (err || !split) begin
            close_segment();
        end
        if (err) begin
            ref_q.push_back(8'h02);
        end
        if (cobs_pkg::APPEND_ZERO) begin
            ref_q.push_back(8'h00);
        end
    endtask

    task automatic add_frame(input bit err, input bit stall);
        int last;
        encode_reference(err);
        last = frame.size() - 1;
        for (int i = 0; i <= last; i++) begin
            in_q.push_back({stall, frame[i], i == last, err && i == last});
        end
        last = ref_q.size() - 1;
        for (int j = 0; j <= last; j++) begin
            exp_q.push_back({ref_q[j], j == last, err && j == last});
        end
        exp_len.push_back(ref_q.size());
    endtask

    // expected bytes in the file cross-check the reference encoder
    task automatic compare_model();
        bit same;
        same = (file_exp.size() == ref_q.size());
        foreach (file_exp[i]) begin
            if (same && file_exp[i] != ref_q[i]) begin
                same = 1'b0;
            end
        end
        assert (same) else begin
            $display("reference encoder disagrees with the file for frame %0d",
                     exp_len.size() - 1);
            errors++;
        end
    endtask

    task automatic read_stimulus(output bit opened);
        int fd;
        int n;
        int v;
        int mode;
        bit stall;
        string tok;
        string rest;
        fd = $fopen("verif/cobs_input.txt", "r");
        opened = (fd != 0);
        stall = 1'b0;
        mode = 0;
        while (opened && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                v = $fgets(rest, fd);
            end else if (tok == "stall") begin
                stall = 1'b1;
            end else if (tok == "gen") begin
                v = $fscanf(fd, "%d", n);
                frame.delete();
                repeat (n) begin
                    // zero draws are repeated
                    do begin
                        lfsr_bits(gen_state, 8, v);
                    end while (v == 0);
                    frame.push_back(v[7:0]);
                end
                add_frame(1'b0, stall);
            end else if (tok == "frame") begin
                mode = 1;
                frame.delete();
            end else if (tok == "exp") begin
                mode = 2;
                file_exp.delete();
            end else if (tok == "end" || tok == "err") begin
                if (mode == 1) begin
                    add_frame(tok == "err", stall);
                end else begin
                    compare_model();
                end
                mode = 0;
            end else begin
                v = $sscanf(tok, "%h", n);
                if (mode == 1) begin
                    frame.push_back(n[7:0]);
                end else begin
                    file_exp.push_back(n[7:0]);
                end
            end
        end
        if (opened) begin
            $fclose(fd);
        end
    endtask

    task automatic send_all();
        int gap;
        foreach (in_q[k]) begin
            stall_on = in_q[k][10];
            lfsr_bits(gen_state, 2, gap);
            while (in_q[k][10] && gap == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
                lfsr_bits(gen_state, 2, gap);
            end
            in_beat = in_q[k][9:0];
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic check_all();
        int k;
        int bad;
        cobs_pkg::stream_beat_t got;
        k = 0;
        foreach (exp_len[f]) begin
            bad = 0;
            for (int j = 0; j < exp_len[f]; j++) begin
                @(negedge clk);
                while (!(out_valid && out_ready)) begin
                    @(negedge clk);
                end
                got = out_beat;
                assert (got == exp_q[k]) else begin
                    $display("FAILED at %0t: frame %0d byte %0d got %h/%b/%b expected %h/%b/%b",
                             $time, f, j, got.data, got.last, got.user,
                             exp_q[k][9:2], exp_q[k][1], exp_q[k][0]);
                    bad++;
                end
                k++;
            end
            $display("frame %0d: %0d output bytes, %s", f, exp_len[f],
                     bad == 0 ? "ok" : "mismatch");
            if (bad == 0) begin
                frames_ok++;
            end else begin
                frames_bad++;
            end
            errors += bad;
        end
    endtask

    // every frame end leaving the DUT, extra ones included
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready && out_beat.last) begin
            out_lasts++;
        end
    end

    // sink back-pressure once stalls are enabled
    always @(posedge clk) begin
        stall_now = stall_on;
        #1;
        if (stall_now) begin
            lfsr_bits(ready_state, 2, ready_draw);
            out_ready = (ready_draw != 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    initial begin
        wait (watchdog_time > 0);
        #(watchdog_time);
        $display("watchdog expired, the output stalled before all frames came out");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit opened;
        clk = 1'b0;
        rst = 1'b1;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        stall_on = 1'b0;
        gen_state = 32'h62b0;
        ready_state = 32'h62b0;
        errors = 0;
        frames_ok = 0;
        frames_bad = 0;
        out_lasts = 0;
        read_stimulus(opened);
        if (!opened) begin
            $display("could not open the stimulus file verif/cobs_input.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            watchdog_time = (longint'(in_q.size()) * 4000 + 2000) * CLK_PERIOD;
            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            fork
                send_all();
                check_all();
            join
            repeat (DRAIN_CYCLES) @(posedge clk);
            assert (out_lasts == exp_len.size()) else begin
                $display("frame count mismatch, %0d frames sent but %0d frame ends seen",
                         exp_len.size(), out_lasts);
                errors++;
            end
            $display("frames passed %0d, failed %0d, errors %0d", frames_ok, frames_bad, errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/cobs_encode_top.sv
`default_nettype none

module cobs_encode_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cobs_pkg::stream_beat_t in_beat,
    input  wire                    in_valid,
    output logic                   in_ready,
    output cobs_pkg::stream_beat_t out_beat,
    output logic                   out_valid,
    input  wire                    out_ready
);

    // segmenter to FIFOs
    cobs_pkg::stream_beat_t code_wr;
    logic code_wr_valid;
    logic code_wr_ready;
    cobs_pkg::data_beat_t data_wr;
    logic data_wr_valid;
    logic data_wr_ready;

    // FIFOs to emitter
    cobs_pkg::stream_beat_t code_rd;
    logic code_rd_valid;
    logic code_rd_ready;
    cobs_pkg::data_beat_t data_rd;
    logic data_rd_valid;
    logic data_rd_ready;

    // emitter to output stage
    cobs_pkg::stream_beat_t emit_beat;
    logic emit_valid;
    logic emit_ready;

    cobs_segmenter segmenter (
        .clk           (clk),
        .rst           (rst),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .code_wr       (code_wr),
        .code_wr_valid (code_wr_valid),
        .code_wr_ready (code_wr_ready),
        .data_wr       (data_wr),
        .data_wr_valid (data_wr_valid),
        .data_wr_ready (data_wr_ready)
    );

    stream_fifo #(.WIDTH($bits(cobs_pkg::stream_beat_t))) code_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (code_wr),
        .wr_valid (code_wr_valid),
        .wr_ready (code_wr_ready),
        .rd_data  (code_rd),
        .rd_valid (code_rd_valid),
        .rd_ready (code_rd_ready)
    );

    stream_fifo #(.WIDTH($bits(cobs_pkg::data_beat_t))) data_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (data_wr),
        .wr_valid (data_wr_valid),
        .wr_ready (data_wr_ready),
        .rd_data  (data_rd),
        .rd_valid (data_rd_valid),
        .rd_ready (data_rd_ready)
    );

    cobs_emitter emitter (
        .clk           (clk),
        .rst           (rst),
        .code_rd       (code_rd),
        .code_rd_valid (code_rd_valid),
        .code_rd_ready (code_rd_ready),
        .data_rd       (data_rd),
        .data_rd_valid (data_rd_valid),
        .data_rd_ready (data_rd_ready),
        .emit_beat     (emit_beat),
        .emit_valid    (emit_valid),
        .emit_ready    (emit_ready)
    );

    stream_skid_buffer skid_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (emit_beat),
        .in_valid  (emit_valid),
        .in_ready  (emit_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: src/stream_skid_buffer.sv
`default_nettype none

module stream_skid_buffer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cobs_pkg::stream_beat_t in_beat,
    input  wire                    in_valid,
    output logic                   in_ready,
    output cobs_pkg::stream_beat_t out_beat,
    output logic                   out_valid,
    input  wire                    out_ready
);

    cobs_pkg::stream_beat_t temp_beat;
    logic temp_valid;
    logic out_valid_next;
    logic temp_valid_next;
    logic ready_early;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // next cycle can accept if the sink drains or the temp register stays empty
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // sink stalled, park the beat
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat <= in_beat;
        end else if (store_temp_to_out) begin
            out_beat <= temp_beat;
        end
        if (store_in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: src/cobs_emitter.sv
`default_nettype none

module cobs_emitter (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cobs_pkg::stream_beat_t code_rd,
    input  wire                    code_rd_valid,
    output logic                   code_rd_ready,
    input  wire cobs_pkg::data_beat_t   data_rd,
    input  wire                    data_rd_valid,
    output logic                   data_rd_ready,
    output cobs_pkg::stream_beat_t emit_beat,
    output logic                   emit_valid,
    input  wire                    emit_ready
);

    cobs_pkg::emit_state_t state;
    cobs_pkg::emit_state_t state_next;

    // data bytes still owed to the current code
    cobs_pkg::code_t remain;
    cobs_pkg::code_t remain_next;

    always_comb begin
        state_next = state;
        remain_next = remain;
        emit_beat = '0;
        emit_valid = 1'b0;
        code_rd_ready = 1'b0;
        data_rd_ready = 1'b0;

        case (state)
            cobs_pkg::EMIT_CODE: begin
                if (emit_ready && code_rd_valid) begin
                    emit_beat.data = code_rd.data;
                    emit_beat.last = code_rd.last;
                    emit_beat.user = code_rd.user && code_rd.last;
                    emit_valid = 1'b1;
                    code_rd_ready = 1'b1;
                    remain_next = code_rd.data - 8'd1;
                    // codes 0 and 1 and the error code carry no data
                    if (code_rd.data > 8'd1 && !code_rd.user) begin
                        state_next = cobs_pkg::EMIT_DATA;
                    end
                end
            end
            cobs_pkg::EMIT_DATA: begin
                if (emit_ready && data_rd_valid) begin
                    emit_beat.data = data_rd.data;
                    emit_beat.last = data_rd.last;
                    emit_valid = 1'b1;
                    data_rd_ready = 1'b1;
                    remain_next = remain - 8'd1;
                    if (remain == 8'd1) begin
                        state_next = cobs_pkg::EMIT_CODE;
                    end
                end
            end
            default: begin
                state_next = cobs_pkg::EMIT_CODE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::EMIT_CODE;
            remain <= '0;
        end else begin
            state <= state_next;
            remain <= remain_next;
        end
    end

endmodule

`default_nettype wire

// File: src/cobs_segmenter.sv
`default_nettype none

module cobs_segmenter (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cobs_pkg::stream_beat_t in_beat,
    input  wire                    in_valid,
    output logic                   in_ready,
    output cobs_pkg::stream_beat_t code_wr,
    output logic                   code_wr_valid,
    input  wire                    code_wr_ready,
    output cobs_pkg::data_beat_t   data_wr,
    output logic                   data_wr_valid,
    input  wire                    data_wr_ready
);

    cobs_pkg::seg_state_t state;
    cobs_pkg::seg_state_t state_next;

    // code value the open segment would get if closed now
    cobs_pkg::code_t count;
    cobs_pkg::code_t count_next;
    cobs_pkg::code_t open_count;

    // frame ended with the error flag
    logic fail;
    logic fail_next;

    logic accept;
    logic end_segment;

    assign in_ready = code_wr_ready && data_wr_ready &&
                      (state == cobs_pkg::SEG_IDLE || state == cobs_pkg::SEG_RUN);
    assign accept = in_valid && in_ready;

    // a zero byte or an errored last byte closes the segment without data
    assign end_segment = (in_beat.data == '0) || (in_beat.last && in_beat.user);

    // no segment open in idle, same as an empty one
    assign open_count = (state == cobs_pkg::SEG_RUN) ? count : 8'd1;

    always_comb begin
        state_next = state;
        count_next = count;
        fail_next = fail;
        code_wr = '0;
        code_wr_valid = 1'b0;
        data_wr.data = in_beat.data;
        // frame end is always marked by the delimiter code
        data_wr.last = 1'b0;
        data_wr_valid = 1'b0;

        case (state)
            cobs_pkg::SEG_IDLE, cobs_pkg::SEG_RUN: begin
                if (accept) begin
                    if (end_segment) begin
                        code_wr.data = open_count;
                        code_wr_valid = 1'b1;
                        if (in_beat.last) begin
                            fail_next = in_beat.user;
                            state_next = cobs_pkg::SEG_FINAL_CODE;
                        end else begin
                            state_next = cobs_pkg::SEG_IDLE;
                        end
                    end else begin
                        data_wr_valid = 1'b1;
                        count_next = open_count + 8'd1;
                        if (open_count == cobs_pkg::code_t'(cobs_pkg::MAX_CODE - 1)) begin
                            // full segment, close it and keep counting
                            code_wr.data = cobs_pkg::code_t'(cobs_pkg::MAX_CODE);
                            code_wr_valid = 1'b1;
                            count_next = 8'd1;
                        end
                        if (in_beat.last) begin
                            code_wr.data = open_count + 8'd1;
                            code_wr_valid = 1'b1;
                            state_next = cobs_pkg::SEG_DELIM;
                        end else begin
                            state_next = cobs_pkg::SEG_RUN;
                        end
                    end
                end
            end
            cobs_pkg::SEG_FINAL_CODE: begin
                // trailing zero, or code 2 flagged as the error marker
                if (code_wr_ready) begin
                    code_wr.data = fail ? 8'd2 : 8'd1;
                    code_wr.user = fail;
                    code_wr_valid = 1'b1;
                    state_next = cobs_pkg::SEG_DELIM;
                end
            end
            cobs_pkg::SEG_DELIM: begin
                if (code_wr_ready) begin
                    code_wr.data = 8'd0;
                    code_wr.last = 1'b1;
                    code_wr.user = fail;
                    code_wr_valid = 1'b1;
                    fail_next = 1'b0;
                    state_next = cobs_pkg::SEG_IDLE;
                end
            end
            default: begin
                state_next = cobs_pkg::SEG_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::SEG_IDLE;
            count <= 8'd1;
            fail <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            fail <= fail_next;
        end
    end

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
`default_nettype none

module stream_fifo #(
    parameter int WIDTH = 8
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [WIDTH-1:0]  wr_data,
    input  wire              wr_valid,
    output logic             wr_ready,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  wire              rd_ready
);

    localparam int AW = cobs_pkg::FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    logic [WIDTH-1:0] mem [DEPTH];

    // one extra bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic full;
    logic empty;
    logic do_write;
    logic do_read;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready = !full;
    assign rd_valid = !empty;

    assign do_write = wr_valid && !full;
    assign do_read = rd_ready && !empty;

    // head entry is read straight from the array, first word falls through
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/cobs_pkg.sv
`default_nettype none

package cobs_pkg;

    // largest COBS code, closes a segment of 254 data bytes
    localparam int MAX_CODE = 255;

    // each output frame ends with a 0x00 delimiter
    localparam bit APPEND_ZERO = 1'b1;

    // 256 entries per FIFO, room for one full segment
    localparam int FIFO_DEPTH_LOG2 = 8;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] code_t;

    // stream beat, also the code FIFO entry
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

    // data FIFO entry
    typedef struct packed {
        byte_t data;
        logic  last;
    } data_beat_t;

    typedef enum logic [1:0] {
        SEG_IDLE,
        SEG_RUN,
        SEG_FINAL_CODE,
        SEG_DELIM
    } seg_state_t;

    typedef enum logic {
        EMIT_CODE,
        EMIT_DATA
    } emit_state_t;

endpackage

`default_nettype wire
